// ==== Bender.yml ====
package:
  name: usbphy

sources:
  - files:
      - source/usbPhyPkg.sv
      - source/usbLineIf.sv
      - source/usbPad.sv
      - source/usbBitTimer.sv
      - source/usbPhyControl.sv
      - source/usbRxDatapath.sv
      - source/usbTxDatapath.sv
      - source/usbPhy.sv
  - target: test
    files:
      - bench/usbPhyTb.sv

// ==== bench/usbPhyTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbPhyTb;

    import usbPhyPkg::*;

    typedef struct packed {
        logic        isTx;
        logic [3:0]  count;       // Bytes in the packet
        logic [3:0]  keep;        // Bytes that must come out of rxData
        logic        badStuff;    // Stuffing left out so seven ones reach the DUT
        logic [63:0] data;        // Byte 0 in the low bits
    } packetT;

    logic        clk48;
    logic        rstN;
    logic        pinP;
    logic        pinN;
    logic        pinPOut;
    logic        pinNOut;
    logic        pinOutEn;
    byteT        txData;
    logic        txValid;
    logic        txReady;
    byteT        rxData;
    logic        rxValid;
    logic        rxActive;
    logic        rxError;

    packetT      packets [7];
    lineStateT   lineQ [$];      // Expected bus state per bit
    lineStateT   capQ [$];       // Pin samples, one per clock
    byteT        rxQ [$];
    int          errCount;
    logic        sawActive;
    logic [16:0] lfsr;

    usbPhy usbPhy_inst (
        .clk48    (clk48),
        .rstN     (rstN),
        .pinP     (pinP),
        .pinN     (pinN),
        .pinPOut  (pinPOut),
        .pinNOut  (pinNOut),
        .pinOutEn (pinOutEn),
        .txData   (txData),
        .txValid  (txValid),
        .txReady  (txReady),
        .rxData   (rxData),
        .rxValid  (rxValid),
        .rxActive (rxActive),
        .rxError  (rxError)
    );

    initial begin
        clk48 = 1'b0;
        forever #2 clk48 = ~clk48;
    end

    // Receive side outputs sampled mid-cycle
    always @(negedge clk48) begin
        if (rxValid) rxQ.push_back(rxData);
        if (rxError) errCount = errCount + 1;
        if (rxActive) sawActive = 1'b1;
    end

    function automatic logic [16:0] stepLfsr(input logic [16:0] cur);
        return {cur[15:0], cur[16] ^ cur[13]};   // x^17 + x^14 + 1
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input byteT got, input byteT exp);
        if (got !== exp)
            abortRun($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkLine(input string name, input lineStateT got, input lineStateT exp);
        if (got !== exp)
            abortRun($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp));
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp)
            abortRun($sformatf("Fail at %0t ns: %s got %0d, expected %0d", $time, name, got, exp));
    endtask

    // Expected bus states for SYNC and the bytes in stuffed NRZI followed by EOP and one J bit
    task automatic encodePacket(input packetT pkt);
        byteT cur;
        logic level;
        int   ones;
        int   n;
        int   b;
        lineQ.delete();
        level = 1'b1;
        ones = 0;
        for (n = 0; n <= pkt.count; n++) begin
            cur = syncByte;
            if (n > 0) cur = pkt.data[8*n-8 +: 8];
            for (b = 0; b < 8; b++) begin
                if (!cur[b]) level = !level;        // A zero toggles the line
                lineQ.push_back(lineStateT'({level, !level}));
                ones = cur[b] ? ones + 1 : 0;
                if (ones == stuffRun && !pkt.badStuff) begin
                    level = !level;
                    lineQ.push_back(lineStateT'({level, !level}));
                    ones = 0;
                end
            end
        end
        for (b = 0; b < eopBits; b++) lineQ.push_back(se0);
        lineQ.push_back(j);
    endtask

    task automatic receivePacket(input packetT pkt);
        logic [1:0] offset;
        logic [1:0] lvl;
        int         i;
        int         waited;
        encodePacket(pkt);
        rxQ.delete();
        errCount = 0;
        sawActive = 1'b0;
        lfsr = stepLfsr(lfsr);
        offset[0] = lfsr[0];
        lfsr = stepLfsr(lfsr);
        offset[1] = lfsr[0];
        repeat (offset) @(posedge clk48);             // Line phase against the clock
        @(posedge clk48);
        for (i = 0; i < lineQ.size(); i++) begin
            lvl = lineQ[i];
            pinP <= lvl[1];
            pinN <= lvl[0];
            repeat (bitCycles) @(posedge clk48);
        end
        waited = 0;
        do begin
            @(negedge clk48);
            waited++;
            if (waited > 10 * bitCycles) abortRun("Timeout waiting for rxActive to fall");
        end while (rxActive);
        repeat (5 * bitCycles) @(posedge clk48);     // Idle gap before the next packet
        checkBit("rxActive seen", sawActive, 1'b1);
        checkCount("rxError pulses", errCount, pkt.badStuff ? 1 : 0);
        checkCount("rxValid count", rxQ.size(), pkt.keep);
        for (i = 0; i < rxQ.size(); i++) checkByte("rxData", rxQ[i], pkt.data[8*i +: 8]);
    endtask

    task automatic transmitPacket(input packetT pkt);
        int   sent;
        int   cycles;
        int   i;
        logic enNow;
        logic accepted;
        logic echoP;
        logic echoN;
        encodePacket(pkt);
        capQ.delete();
        rxQ.delete();
        errCount = 0;
        sent = 0;
        cycles = 0;
        @(posedge clk48);
        txData  <= pkt.data[7:0];
        txValid <= 1'b1;
        do begin
            @(negedge clk48);
            enNow    = pinOutEn;
            accepted = txValid && txReady;
            echoP    = enNow ? pinPOut : 1'b1;        // Own traffic seen on the inputs
            echoN    = enNow ? pinNOut : 1'b0;
            if (enNow) capQ.push_back(lineStateT'({pinPOut, pinNOut}));
            @(posedge clk48);
            pinP <= echoP;
            pinN <= echoN;
            if (accepted) begin
                sent++;
                if (sent < pkt.count) txData <= pkt.data[8*sent +: 8];
                else txValid <= 1'b0;
            end
            cycles++;
            if (cycles > (pkt.count + 4) * 12 * bitCycles)
                abortRun("Timeout waiting for the transmit packet to finish");
        end while (sent < pkt.count || enNow);
        checkCount("pin sample count", capQ.size(), lineQ.size() * bitCycles);
        for (i = 0; i < capQ.size(); i++) begin
            checkLine("pinPOut/pinNOut", capQ[i], lineQ[i / bitCycles]);
        end
        checkCount("rxValid count while sending", rxQ.size(), 0);
        checkCount("rxError pulses while sending", errCount, 0);
    endtask

    initial begin
        int p;
        rstN     = 1'b0;
        pinP     = 1'b1;                             // Idle J
        pinN     = 1'b0;
        txData   = '0;
        txValid  = 1'b0;
        errCount = 0;
        lfsr     = 17'd73102;
        // isTx, count, keep, badStuff, bytes
        packets[0] = {1'b0, 4'd3, 4'd3, 1'b0, 64'h0000_0000_00A5_3C01};
        packets[1] = {1'b0, 4'd4, 4'd4, 1'b0, 64'h0000_0000_7E00_FFFF};
        packets[2] = {1'b1, 4'd3, 4'd0, 1'b0, 64'h0000_0000_0012_FFC3};
        packets[3] = {1'b0, 4'd4, 4'd1, 1'b1, 64'h0000_0000_1180_FF5A};
        packets[4] = {1'b0, 4'd8, 4'd8, 1'b0, 64'h8877_6655_4433_2211};
        packets[5] = {1'b1, 4'd2, 4'd0, 1'b0, 64'h0000_0000_0000_FC3F};
        packets[6] = {1'b0, 4'd1, 4'd1, 1'b0, 64'h0000_0000_0000_00FC};
        repeat (3) @(posedge clk48);
        rstN <= 1'b1;
        @(negedge clk48);
        checkBit("pinOutEn", pinOutEn, 1'b0);
        checkBit("txReady", txReady, 1'b0);
        checkBit("rxValid", rxValid, 1'b0);
        checkBit("rxActive", rxActive, 1'b0);
        checkBit("rxError", rxError, 1'b0);
        for (p = 0; p < $size(packets); p++) begin
            if (packets[p].isTx) transmitPacket(packets[p]);
            else receivePacket(packets[p]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/usbBitTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbBitTimer (
    input  logic  clk48,
    input  logic  rstN,
    usbLineIf.phy line,
    input  logic  txActive,
    output logic  sampleStrobe,
    output logic  txStrobe
);

    import usbPhyPkg::*;

    logic [$clog2(bitCycles)-1:0] rxPhase;   // Position inside the received bit
    logic [$clog2(bitCycles)-1:0] txCount;
    logic prevP;
    logic prevPNeg;
    logic edgeSeen;

    // Either sampler may see the edge first; the later one is ignored
    assign edgeSeen = (line.dataInP != prevP) || (line.dataInPNeg != prevPNeg);

    assign sampleStrobe = (rxPhase == bitCycles / 2 - 1);        // Mid-bit
    assign txStrobe     = txActive && (txCount == bitCycles - 1); // Last clock of a bit

    always_ff @(posedge clk48) begin
        if (!rstN) begin
            rxPhase  <= '0;
            txCount  <= '0;
            prevP    <= 1'b1;
            prevPNeg <= 1'b1;
        end else begin
            prevP    <= line.dataInP;
            prevPNeg <= line.dataInPNeg;
            if (edgeSeen && rxPhase != '0) begin
                rxPhase <= '0;                                   // Realign on the edge
            end else begin
                rxPhase <= (rxPhase == bitCycles - 1) ? '0 : rxPhase + 1'b1;
            end
            if (!txActive) begin
                txCount <= '0;
            end else begin
                txCount <= (txCount == bitCycles - 1) ? '0 : txCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/usbLineIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface usbLineIf;

    logic outEn;        // Pins driven by the PHY
    logic dataOutP;
    logic dataOutN;
    logic dataInP;      // Synchronized line, J while driving
    logic dataInPNeg;   // Same, via the falling-edge sampler
    logic dataInN;

    modport pad (
        input  outEn, dataOutP, dataOutN,
        output dataInP, dataInPNeg, dataInN
    );

    modport phy (
        output outEn, dataOutP, dataOutN,
        input  dataInP, dataInPNeg, dataInN
    );

endinterface

`default_nettype wire

// ==== source/usbPad.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbPad (
    input  logic   clk48,
    input  logic   rstN,
    input  logic   pinP,
    input  logic   pinN,
    output logic   pinPOut,
    output logic   pinNOut,
    usbLineIf.pad  line
);

    logic [1:0] syncP;     // Two-stage synchronizers against metastability
    logic [1:0] syncPNeg;
    logic [1:0] syncN;

    assign pinPOut = line.outEn ? line.dataOutP : 1'bz;   // Released when not sending
    assign pinNOut = line.outEn ? line.dataOutN : 1'bz;

    // Falling-edge copy of D+ gives the bit timer half a clock more resolution
    always_ff @(negedge clk48) begin
        if (!rstN) begin
            syncPNeg <= 2'b11;
        end else begin
            syncPNeg <= {syncPNeg[0], pinP};
        end
    end

    always_ff @(posedge clk48) begin
        if (!rstN) begin
            syncP           <= 2'b11;                 // Idle J
            syncN           <= 2'b00;
            line.dataInP    <= 1'b1;
            line.dataInPNeg <= 1'b1;
            line.dataInN    <= 1'b0;
        end else begin
            syncP           <= {syncP[0], pinP};
            syncN           <= {syncN[0], pinN};
            line.dataInP    <= line.outEn ? 1'b1 : syncP[1];   // Own traffic reads as J
            line.dataInPNeg <= line.outEn ? 1'b1 : syncPNeg[1];
            line.dataInN    <= line.outEn ? 1'b0 : syncN[1];
        end
    end

endmodule

`default_nettype wire

// ==== source/usbPhy.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbPhy (
    input  logic            clk48,
    input  logic            rstN,
    input  logic            pinP,
    input  logic            pinN,
    output logic            pinPOut,
    output logic            pinNOut,
    output logic            pinOutEn,
    input  usbPhyPkg::byteT txData,
    input  logic            txValid,
    output logic            txReady,
    output usbPhyPkg::byteT rxData,
    output logic            rxValid,
    output logic            rxActive,
    output logic            rxError
);

    import usbPhyPkg::*;

    usbLineIf  line ();

    lineStateT lineState;
    phyStateT  state;
    logic      sampleStrobe;
    logic      txStrobe;
    logic      txActive;
    logic      syncSeen;
    logic      eopSeen;
    logic      txByteDone;
    logic      eopDone;

    assign pinOutEn = line.outEn;

    usbPad usbPad_inst (
        .clk48   (clk48),
        .rstN    (rstN),
        .pinP    (pinP),
        .pinN    (pinN),
        .pinPOut (pinPOut),
        .pinNOut (pinNOut),
        .line    (line)
    );

    usbBitTimer usbBitTimer_inst (
        .clk48        (clk48),
        .rstN         (rstN),
        .line         (line),
        .txActive     (txActive),
        .sampleStrobe (sampleStrobe),
        .txStrobe     (txStrobe)
    );

    usbPhyControl usbPhyControl_inst (
        .clk48      (clk48),
        .rstN       (rstN),
        .lineState  (lineState),
        .syncSeen   (syncSeen),
        .eopSeen    (eopSeen),
        .stuffError (rxError),
        .txValid    (txValid),
        .txByteDone (txByteDone),
        .eopDone    (eopDone),
        .state      (state),
        .txActive   (txActive),
        .rxActive   (rxActive)
    );

    usbRxDatapath usbRxDatapath_inst (
        .clk48        (clk48),
        .rstN         (rstN),
        .line         (line),
        .sampleStrobe (sampleStrobe),
        .state        (state),
        .lineState    (lineState),
        .syncSeen     (syncSeen),
        .eopSeen      (eopSeen),
        .stuffError   (rxError),
        .rxData       (rxData),
        .rxValid      (rxValid)
    );

    usbTxDatapath usbTxDatapath_inst (
        .clk48      (clk48),
        .rstN       (rstN),
        .line       (line),
        .txStrobe   (txStrobe),
        .state      (state),
        .txData     (txData),
        .txValid    (txValid),
        .txReady    (txReady),
        .txByteDone (txByteDone),
        .eopDone    (eopDone)
    );

endmodule

`default_nettype wire

// ==== source/usbPhyControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbPhyControl (
    input  logic                 clk48,
    input  logic                 rstN,
    input  usbPhyPkg::lineStateT lineState,
    input  logic                 syncSeen,
    input  logic                 eopSeen,
    input  logic                 stuffError,
    input  logic                 txValid,
    input  logic                 txByteDone,
    input  logic                 eopDone,
    output usbPhyPkg::phyStateT  state,
    output logic                 txActive,
    output logic                 rxActive
);

    import usbPhyPkg::*;

    phyStateT nextState;
    logic     dropPacket;   // Rest of a bad packet is ignored

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (txValid) begin
                    nextState = txSync;                 // Transmit wins over the bus
                end else if (lineState == k) begin
                    nextState = rxHunt;
                end
            end
            rxHunt: begin
                if (eopSeen) begin
                    nextState = idle;
                end else if (syncSeen && !dropPacket) begin
                    nextState = rxData;
                end
            end
            rxData: begin
                if (eopSeen) begin
                    nextState = idle;
                end else if (stuffError) begin
                    nextState = rxHunt;                 // Wait for the line to settle
                end
            end
            txSync, txData: begin
                if (txByteDone) begin
                    nextState = txValid ? txData : txEop;
                end
            end
            txEop: begin
                if (eopDone) begin
                    nextState = txIdle;
                end
            end
            txIdle: begin
                if (eopDone) begin
                    nextState = idle;                   // J bit done
                end
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clk48) begin
        if (!rstN) begin
            state      <= idle;
            txActive   <= 1'b0;
            rxActive   <= 1'b0;
            dropPacket <= 1'b0;
        end else begin
            state    <= nextState;
            txActive <= nextState inside {txSync, txData, txEop, txIdle};
            rxActive <= (nextState == rxData);
            if (nextState == idle) begin
                dropPacket <= 1'b0;
            end else if (stuffError) begin
                dropPacket <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/usbPhyPkg.sv ====
`default_nettype none

package usbPhyPkg;

    typedef logic [7:0] byteT;

    // Bus state as {D+, D-}
    typedef enum logic [1:0] {
        se0 = 2'b00,
        k   = 2'b01,
        j   = 2'b10,
        se1 = 2'b11
    } lineStateT;

    typedef enum logic [2:0] {
        idle,
        rxHunt,
        rxData,
        txSync,
        txData,
        txEop,
        txIdle
    } phyStateT;

    localparam int bitCycles = 4;         // clk48 cycles per full-speed bit
    localparam byteT syncByte = 8'h80;    // KJKJKJKK on the wire
    localparam int stuffRun = 6;          // Ones before a stuffed zero
    localparam int eopBits = 2;           // SE0 bit times in an EOP

endpackage

`default_nettype wire

// ==== source/usbRxDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbRxDatapath (
    input  logic                 clk48,
    input  logic                 rstN,
    usbLineIf.phy                line,
    input  logic                 sampleStrobe,
    input  usbPhyPkg::phyStateT  state,
    output usbPhyPkg::lineStateT lineState,
    output logic                 syncSeen,
    output logic                 eopSeen,
    output logic                 stuffError,
    output usbPhyPkg::byteT      rxData,
    output logic                 rxValid
);

    import usbPhyPkg::*;

    byteT       shiftReg;
    byteT       shiftNext;
    logic [2:0] bitCount;
    logic [2:0] onesCount;
    logic [1:0] se0Count;
    logic       prevLevel;    // D+ of the last data bit
    logic       rxBit;
    logic       listening;
    logic       endOfPacket;
    logic       levelBit;
    logic       stuffBit;
    logic       dataBit;

    assign lineState = lineStateT'({line.dataInP, line.dataInN});
    assign rxBit     = (line.dataInP == prevLevel);   // NRZI, no change is a one
    assign shiftNext = {rxBit, shiftReg[7:1]};        // LSB arrives first

    assign listening   = sampleStrobe && (state == rxHunt || state == usbPhyPkg::rxData);
    assign endOfPacket = listening && lineState != se0 && se0Count == eopBits;
    assign levelBit    = listening && lineState != se0 && !endOfPacket;
    assign stuffBit    = levelBit && onesCount == stuffRun;
    assign dataBit     = levelBit && !stuffBit;

    always_ff @(posedge clk48) begin
        if (!rstN) begin
            syncSeen   <= 1'b0;
            eopSeen    <= 1'b0;
            stuffError <= 1'b0;
            rxValid    <= 1'b0;
            bitCount   <= '0;
            onesCount  <= '0;
            se0Count   <= '0;
            prevLevel  <= 1'b1;
        end else begin
            syncSeen   <= 1'b0;
            eopSeen    <= endOfPacket && lineState == j;
            stuffError <= stuffBit && rxBit && state == usbPhyPkg::rxData;   // Seventh one
            rxValid    <= dataBit && state == usbPhyPkg::rxData && bitCount == 3'd7;
            if (state == idle) begin
                bitCount  <= '0;
                onesCount <= '0;
                se0Count  <= '0;
                prevLevel <= 1'b1;
            end else if (listening && lineState == se0) begin
                if (se0Count != eopBits) begin
                    se0Count <= se0Count + 1'b1;
                end
            end else if (listening) begin
                se0Count <= '0;
            end
            if (levelBit) begin
                prevLevel <= line.dataInP;
            end
            if (stuffBit) begin
                onesCount <= '0;                             // Stuffed zero dropped
            end else if (dataBit) begin
                onesCount <= rxBit ? onesCount + 1'b1 : 3'd0;
                bitCount  <= bitCount + 1'b1;
                if (state == rxHunt && shiftNext == syncByte) begin
                    syncSeen <= 1'b1;
                    bitCount <= '0;                          // Byte boundary follows SYNC
                end
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (state == idle) begin
            shiftReg <= '1;               // No zeros to fake a SYNC
        end else if (dataBit) begin
            shiftReg <= shiftNext;
        end
        if (dataBit && bitCount == 3'd7) begin
            rxData <= shiftNext;
        end
    end

endmodule

`default_nettype wire

// ==== source/usbTxDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbTxDatapath (
    input  logic                clk48,
    input  logic                rstN,
    usbLineIf.phy               line,
    input  logic                txStrobe,
    input  usbPhyPkg::phyStateT state,
    input  usbPhyPkg::byteT     txData,
    input  logic                txValid,
    output logic                txReady,
    output logic                txByteDone,
    output logic                eopDone
);

    import usbPhyPkg::*;

    byteT       shiftReg;
    logic [2:0] bitCount;
    logic [2:0] onesCount;
    logic [1:0] eopCount;
    logic       prevLevel;     // Level of the previous bit, J = 1
    logic       curLevel;
    logic       stuffPending;
    logic       sending;
    logic       byteEnd;

    assign sending      = (state == txSync) || (state == usbPhyPkg::txData);
    assign stuffPending = (onesCount == stuffRun);
    assign curLevel     = (stuffPending || !shiftReg[0]) ? !prevLevel : prevLevel;

    assign byteEnd    = txStrobe && sending && !stuffPending && bitCount == 3'd7;
    assign txReady    = byteEnd;
    assign txByteDone = byteEnd;
    assign eopDone    = txStrobe && ((state == txEop && !stuffPending && eopCount == eopBits - 1)
                                     || state == txIdle);

    assign line.outEn = state inside {txSync, usbPhyPkg::txData, txEop, txIdle};

    always_comb begin
        if (state == txEop && !stuffPending) begin
            line.dataOutP = 1'b0;                   // SE0
            line.dataOutN = 1'b0;
        end else if (state == txIdle || !line.outEn) begin
            line.dataOutP = 1'b1;                   // J
            line.dataOutN = 1'b0;
        end else begin
            line.dataOutP = curLevel;
            line.dataOutN = !curLevel;
        end
    end

    always_ff @(posedge clk48) begin
        if (!rstN || !line.outEn) begin
            bitCount  <= '0;
            onesCount <= '0;
            eopCount  <= '0;
            prevLevel <= 1'b1;
        end else if (txStrobe) begin
            prevLevel <= curLevel;
            if (stuffPending) begin
                onesCount <= '0;                    // Stuffed zero sent, also before EOP
            end else if (state == txEop) begin
                eopCount <= eopCount + 1'b1;
            end else if (sending) begin
                onesCount <= shiftReg[0] ? onesCount + 1'b1 : 3'd0;
                bitCount  <= bitCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (!line.outEn) begin
            shiftReg <= syncByte;                   // Ready for the first bit of SYNC
        end else if (byteEnd && txValid) begin
            shiftReg <= txData;
        end else if (txStrobe && sending && !stuffPending) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/usbPhyPkg.sv
source/usbLineIf.sv
source/usbPad.sv
source/usbBitTimer.sv
source/usbPhyControl.sv
source/usbRxDatapath.sv
source/usbTxDatapath.sv
source/usbPhy.sv
bench/usbPhyTb.sv
